/* hw/rx_pcs_pkg.sv */
// rx pcs package with block widths, header codes, lock thresholds and the idle block
package rx_pcs_pkg;

    localparam int BLOCK_W   = 66;
    localparam int PAYLOAD_W = 64;
    localparam int SH_W      = 2;
    localparam int COUNT_W   = 16;
    localparam int SCR_W     = 58;

    typedef logic [BLOCK_W-1:0]   block_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;
    typedef logic [SH_W-1:0]      sync_header_t;
    typedef logic [COUNT_W-1:0]   count_t;
    typedef logic [SCR_W-1:0]     scr_state_t;

    typedef enum logic
    {
        LOCK_HUNT,
        LOCK_LOCKED
    } lock_state_t;

    localparam sync_header_t SH_DATA = 2'b01;
    localparam sync_header_t SH_CTRL = 2'b10;

    // block lock thresholds
    localparam int LOCK_GOOD_SH     = 16;
    localparam int SH_WINDOW        = 64;
    localparam int SH_INVALID_LIMIT = 8;
    localparam int GOOD_CNT_W       = $clog2(LOCK_GOOD_SH);
    localparam int WIN_CNT_W        = $clog2(SH_WINDOW);
    localparam int INV_CNT_W        = $clog2(SH_INVALID_LIMIT);

    // taps for 1 + x^39 + x^58
    localparam int SCR_TAP_A = 38;
    localparam int SCR_TAP_B = 57;

    // idle control block, type 1e in the first transmitted byte
    localparam logic [7:0] IDLE_BTYPE = 8'h1e;
    localparam block_t IDLE_BLOCK = {SH_CTRL, 56'h0, IDLE_BTYPE};

endpackage

/* hw/block_lock.sv */
// block lock stage that qualifies sync headers and tracks lock on the block stream
module block_lock
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  rx_pcs_pkg::block_t    i_block,
    output logic                  o_valid,
    output rx_pcs_pkg::block_t    o_block,
    output logic                  o_lock,
    output logic                  o_sh_invalid
);

    rx_pcs_pkg::lock_state_t              state;
    rx_pcs_pkg::lock_state_t              state_next;
    logic [rx_pcs_pkg::GOOD_CNT_W-1:0]    good_cnt;
    logic [rx_pcs_pkg::GOOD_CNT_W-1:0]    good_next;
    logic [rx_pcs_pkg::WIN_CNT_W-1:0]     win_cnt;
    logic [rx_pcs_pkg::WIN_CNT_W-1:0]     win_next;
    logic [rx_pcs_pkg::INV_CNT_W-1:0]     inv_cnt;
    logic [rx_pcs_pkg::INV_CNT_W-1:0]     inv_next;
    rx_pcs_pkg::sync_header_t             header;
    logic                                 sh_ok;

    assign header = i_block[rx_pcs_pkg::BLOCK_W-1 -: rx_pcs_pkg::SH_W];
    assign sh_ok  = (header == rx_pcs_pkg::SH_DATA) || (header == rx_pcs_pkg::SH_CTRL);

    always_comb
    begin
        state_next = state;
        good_next  = good_cnt;
        win_next   = win_cnt;
        inv_next   = inv_cnt;
        if (i_valid)
        begin
            case (state)
                rx_pcs_pkg::LOCK_HUNT:
                begin
                    // consecutive good headers, any bad one starts over
                    if (!sh_ok)
                        good_next = '0;
                    else if (int'(good_cnt) == rx_pcs_pkg::LOCK_GOOD_SH - 1)
                    begin
                        state_next = rx_pcs_pkg::LOCK_LOCKED;
                        good_next  = '0;
                    end
                    else
                        good_next = good_cnt + 1'b1;
                end
                default:
                begin
                    if (!sh_ok && int'(inv_cnt) == rx_pcs_pkg::SH_INVALID_LIMIT - 1)
                    begin
                        state_next = rx_pcs_pkg::LOCK_HUNT;
                        win_next   = '0;
                        inv_next   = '0;
                    end
                    else if (int'(win_cnt) == rx_pcs_pkg::SH_WINDOW - 1)
                    begin
                        // window closes, both counts restart
                        win_next = '0;
                        inv_next = '0;
                    end
                    else
                    begin
                        win_next = win_cnt + 1'b1;
                        if (!sh_ok)
                            inv_next = inv_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state        <= rx_pcs_pkg::LOCK_HUNT;
            good_cnt     <= '0;
            win_cnt      <= '0;
            inv_cnt      <= '0;
            o_valid      <= 1'b0;
            o_sh_invalid <= 1'b0;
        end
        else
        begin
            state        <= state_next;
            good_cnt     <= good_next;
            win_cnt      <= win_next;
            inv_cnt      <= inv_next;
            o_valid      <= i_valid;
            o_sh_invalid <= i_valid && !sh_ok;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_block <= i_block;
    end

    // state register moves with o_valid, so lock lines up with its block
    assign o_lock = (state == rx_pcs_pkg::LOCK_LOCKED);

endmodule

/* hw/descrambler.sv */
// self-synchronizing 64b/66b payload descrambler with bypass
module descrambler
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  rx_pcs_pkg::block_t    i_block,
    input  logic                  i_lock,
    input  logic                  i_bypass,
    output logic                  o_valid,
    output rx_pcs_pkg::block_t    o_block,
    output logic                  o_lock
);

    rx_pcs_pkg::scr_state_t    scr_state;
    rx_pcs_pkg::scr_state_t    scr_next;
    rx_pcs_pkg::payload_t      payload_in;
    rx_pcs_pkg::payload_t      payload_dsc;
    rx_pcs_pkg::sync_header_t  header;

    assign header     = i_block[rx_pcs_pkg::BLOCK_W-1 -: rx_pcs_pkg::SH_W];
    assign payload_in = i_block[rx_pcs_pkg::PAYLOAD_W-1:0];

    // lsb first, the received bit feeds the state
    always_comb
    begin
        scr_next = scr_state;
        for (int i = 0; i < rx_pcs_pkg::PAYLOAD_W; i++)
        begin
            payload_dsc[i] = payload_in[i] ^ scr_next[rx_pcs_pkg::SCR_TAP_A]
                           ^ scr_next[rx_pcs_pkg::SCR_TAP_B];
            scr_next = {scr_next[rx_pcs_pkg::SCR_W-2:0], payload_in[i]};
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            scr_state <= '0;
            o_valid   <= 1'b0;
            o_lock    <= 1'b0;
        end
        else
        begin
            // state keeps running in bypass
            if (i_valid)
                scr_state <= scr_next;
            o_valid <= i_valid;
            o_lock  <= i_lock;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_valid)
            o_block <= {header, i_bypass ? payload_in : payload_dsc};
    end

endmodule

/* hw/idle_checker.sv */
// idle test-pattern checker that flags descrambled blocks differing from idle
module idle_checker
(
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_valid,
    input  rx_pcs_pkg::block_t    i_block,
    input  logic                  i_lock,
    output logic                  o_mismatch
);

    logic    armed;
    logic    differs;
    logic    check;

    // full block compare, header included
    assign differs = (i_block != rx_pcs_pkg::IDLE_BLOCK);

    // only judged while locked and past the first block after lock
    assign check = i_valid && i_lock && armed;

    // first locked block may still see an unsettled descrambler
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            armed <= 1'b0;
        else if (!i_lock)
            armed <= 1'b0;
        else if (i_valid)
            armed <= 1'b1;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            o_mismatch <= 1'b0;
        else
            o_mismatch <= check && differs;
    end

endmodule

/* hw/status_bank.sv */
// clear-on-read status bank holding the lock flag and the error counters
module status_bank
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_lock,
    input  logic                   i_sh_invalid,
    input  logic                   i_mismatch,
    input  logic                   i_read_lock,
    input  logic                   i_read_sh_errors,
    input  logic                   i_read_mismatches,
    output logic                   o_lock,
    output rx_pcs_pkg::count_t     o_sh_errors,
    output rx_pcs_pkg::count_t     o_mismatches
);

    logic    read_lock_d;
    logic    read_sh_errors_d;
    logic    read_mismatches_d;
    logic    clr_lock;
    logic    clr_sh_errors;
    logic    clr_mismatches;
    logic    lock_d;
    logic    lock_lost;

    // saturating step, a clear wins over an event in the same cycle
    function automatic rx_pcs_pkg::count_t bump
    (
        rx_pcs_pkg::count_t    value,
        logic                  clear,
        logic                  event_pulse
    );
        if (clear)
            return '0;
        if (event_pulse && value != '1)
            return value + 1'b1;
        return value;
    endfunction

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            read_lock_d       <= 1'b0;
            read_sh_errors_d  <= 1'b0;
            read_mismatches_d <= 1'b0;
        end
        else
        begin
            read_lock_d       <= i_read_lock;
            read_sh_errors_d  <= i_read_sh_errors;
            read_mismatches_d <= i_read_mismatches;
        end
    end

    // rising edges only, a held read clears once
    assign clr_lock       = i_read_lock && !read_lock_d;
    assign clr_sh_errors  = i_read_sh_errors && !read_sh_errors_d;
    assign clr_mismatches = i_read_mismatches && !read_mismatches_d;

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_sh_errors  <= '0;
            o_mismatches <= '0;
        end
        else
        begin
            o_sh_errors  <= bump(o_sh_errors, clr_sh_errors, i_sh_invalid);
            o_mismatches <= bump(o_mismatches, clr_mismatches, i_mismatch);
        end
    end

    // latched low, a falling lock holds the flag at 0 until read
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            lock_d    <= 1'b0;
            lock_lost <= 1'b0;
            o_lock    <= 1'b0;
        end
        else
        begin
            lock_d <= i_lock;
            if (clr_lock)
            begin
                lock_lost <= 1'b0;
                o_lock    <= 1'b0;
            end
            else
            begin
                lock_lost <= lock_lost || (lock_d && !i_lock);
                o_lock    <= i_lock && !lock_lost;
            end
        end
    end

endmodule

/* hw/rx_pcs_top.sv */
// single-lane 64b/66b receive path from block lock to the status bank
module rx_pcs_top
(
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_valid,
    input  rx_pcs_pkg::block_t     i_block,
    input  logic                   i_bypass,
    input  logic                   i_read_lock,
    input  logic                   i_read_sh_errors,
    input  logic                   i_read_mismatches,
    output logic                   o_lock,
    output rx_pcs_pkg::count_t     o_sh_errors,
    output rx_pcs_pkg::count_t     o_mismatches
);

    // block lock to descrambler and status bank
    logic                  lock_valid;
    rx_pcs_pkg::block_t    lock_block;
    logic                  lock_level;
    logic                  lock_sh_invalid;

    // descrambler to idle checker
    logic                  dsc_valid;
    rx_pcs_pkg::block_t    dsc_block;
    logic                  dsc_lock;

    // idle checker to status bank
    logic                  chk_mismatch;

    block_lock u_block_lock
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (i_valid),
        .i_block        (i_block),
        .o_valid        (lock_valid),
        .o_block        (lock_block),
        .o_lock         (lock_level),
        .o_sh_invalid   (lock_sh_invalid)
    );

    descrambler u_descrambler
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (lock_valid),
        .i_block        (lock_block),
        .i_lock         (lock_level),
        .i_bypass       (i_bypass),
        .o_valid        (dsc_valid),
        .o_block        (dsc_block),
        .o_lock         (dsc_lock)
    );

    idle_checker u_idle_checker
    (
        .i_clock        (i_clock),
        .i_reset        (i_reset),
        .i_valid        (dsc_valid),
        .i_block        (dsc_block),
        .i_lock         (dsc_lock),
        .o_mismatch     (chk_mismatch)
    );

    status_bank u_status_bank
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_lock             (lock_level),
        .i_sh_invalid       (lock_sh_invalid),
        .i_mismatch         (chk_mismatch),
        .i_read_lock        (i_read_lock),
        .i_read_sh_errors   (i_read_sh_errors),
        .i_read_mismatches  (i_read_mismatches),
        .o_lock             (o_lock),
        .o_sh_errors        (o_sh_errors),
        .o_mismatches       (o_mismatches)
    );

endmodule

/* bench/rx_pcs_tb.sv */
// testbench for the single-lane 64b/66b receive path driven by a segment stimulus file
module rx_pcs_tb;

    localparam int MAX_SEGS    = 64;
    localparam int IDLE_CYCLES = 8;
    localparam int READ_CYCLES = 3;
    localparam int NAME_W      = 8 * 32;

    // idle control block payload with block type 1e in the low byte
    localparam rx_pcs_pkg::payload_t IDLE_PAYLOAD = 64'h1e;

    logic                  clock;
    logic                  reset;
    logic                  valid;
    rx_pcs_pkg::block_t    block;
    logic                  bypass;
    logic                  read_lock;
    logic                  read_sh_errors;
    logic                  read_mismatches;
    logic                  lock;
    rx_pcs_pkg::count_t    sh_errors;
    rx_pcs_pkg::count_t    mismatches;

    // one entry per stimulus line
    logic [NAME_W-1:0]     seg_name   [MAX_SEGS];
    int                    seg_count  [MAX_SEGS];
    logic [1:0]            seg_header [MAX_SEGS];
    logic                  seg_random [MAX_SEGS];
    logic                  seg_bypass [MAX_SEGS];
    logic                  seg_errors [MAX_SEGS];
    logic [2:0]            seg_reads  [MAX_SEGS];
    logic                  seg_hold   [MAX_SEGS];
    int                    exp_lock   [MAX_SEGS];
    int                    exp_sh     [MAX_SEGS];
    int                    exp_mm     [MAX_SEGS];
    int                    num_segs;

    int                        cycle_limit = 0;
    int                        cycle_count = 0;
    integer                    seed;
    rx_pcs_pkg::scr_state_t    tx_state;

    rx_pcs_top i_rx_pcs_top
    (
        .i_clock            (clock),
        .i_reset            (reset),
        .i_valid            (valid),
        .i_block            (block),
        .i_bypass           (bypass),
        .i_read_lock        (read_lock),
        .i_read_sh_errors   (read_sh_errors),
        .i_read_mismatches  (read_mismatches),
        .o_lock             (lock),
        .o_sh_errors        (sh_errors),
        .o_mismatches       (mismatches)
    );

    initial
    begin
        clock = 1'b0;
        forever
            #20 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the stimulus did not complete", cycle_count);
            $display("Finished with errors");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // highest non-null byte of a right-justified token
    function automatic logic [7:0] first_char(input logic [NAME_W-1:0] text);
        logic [7:0] c;
        c = 8'h00;
        for (int i = NAME_W / 8 - 1; i >= 0; i--)
            if (c == 8'h00)
                c = text[8*i +: 8];
        return c;
    endfunction

    // transmit side of 1 + x^39 + x^58 where the sent bit feeds the state
    task automatic scramble
    (
        input  rx_pcs_pkg::payload_t    plain,
        output rx_pcs_pkg::payload_t    scrambled
    );
        logic bit_out;
        for (int i = 0; i < rx_pcs_pkg::PAYLOAD_W; i++)
        begin
            bit_out = plain[i] ^ tx_state[rx_pcs_pkg::SCR_TAP_A]
                    ^ tx_state[rx_pcs_pkg::SCR_TAP_B];
            scrambled[i] = bit_out;
            tx_state = {tx_state[rx_pcs_pkg::SCR_W-2:0], bit_out};
        end
    endtask

    task automatic send_segment(input int idx);
        rx_pcs_pkg::payload_t    plain;
        rx_pcs_pkg::payload_t    scrambled;
        logic [1:0]              header;
        for (int k = 0; k < seg_count[idx]; k++)
        begin
            plain = IDLE_PAYLOAD;
            if (seg_random[idx])
            begin
                plain[63:32] = $random(seed);
                plain[31:0]  = $random(seed);
            end
            header = seg_header[idx];
            // every fourth block gets a bad header alternating 00 and 11
            if (seg_errors[idx] && (k % 4 == 3))
                header = ((k / 4) % 2 == 0) ? 2'b00 : 2'b11;
            scramble(plain, scrambled);
            valid = 1'b1;
            block = {header, scrambled};
            @(negedge clock);
            valid = 1'b0;
            @(negedge clock);
        end
    endtask

    task automatic check_value
    (
        input logic [NAME_W-1:0]  test_name,
        input logic [8*16-1:0]    phase,
        input logic [8*16-1:0]    field,
        input int                 expected,
        input int                 actual
    );
        if (expected != actual)
        begin
            $display("[FAIL] %0s %0s %0s expected %0d actual %0d",
                     test_name, phase, field, expected, actual);
            $display("Finished with errors");
            $fatal(1, "an output differs from its expected value");
        end
    endtask

    task automatic check_outputs
    (
        input logic [NAME_W-1:0]  test_name,
        input logic [8*16-1:0]    phase,
        input int                 lock_e,
        input int                 sh_e,
        input int                 mm_e
    );
        check_value(test_name, phase, "lock", lock_e, lock);
        check_value(test_name, phase, "sh_errors", sh_e, sh_errors);
        check_value(test_name, phase, "mismatches", mm_e, mismatches);
    endtask

    // selected outputs read zero right after the clear and the others keep their value
    task automatic issue_reads(input int idx);
        int lock_e;
        int sh_e;
        int mm_e;
        lock_e = seg_reads[idx][2] ? 0 : exp_lock[idx];
        sh_e   = seg_reads[idx][1] ? 0 : exp_sh[idx];
        mm_e   = seg_reads[idx][0] ? 0 : exp_mm[idx];
        // release any held read so the next one is a fresh rising edge
        {read_lock, read_sh_errors, read_mismatches} = 3'b000;
        @(negedge clock);
        {read_lock, read_sh_errors, read_mismatches} = seg_reads[idx];
        @(negedge clock);
        check_outputs(seg_name[idx], "after read", lock_e, sh_e, mm_e);
        if (!seg_hold[idx])
            {read_lock, read_sh_errors, read_mismatches} = 3'b000;
        @(negedge clock);
    endtask

    task automatic load_stimulus;
        int                   fd;
        int                   items;
        int                   total;
        logic [NAME_W-1:0]    name_buf;
        logic [NAME_W-1:0]    kind_buf;
        logic [8*256-1:0]     rest_buf;
        int                   count_v;
        logic [1:0]           header_v;
        int                   bypass_v;
        int                   err_v;
        logic [2:0]           reads_v;
        int                   hold_v;
        int                   lock_v;
        int                   sh_v;
        int                   mm_v;
        num_segs = 0;
        total    = 0;
        fd       = $fopen("bench/rx_pcs_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open bench/rx_pcs_stimulus.txt for reading");
            $display("Finished with errors");
            $fatal(1, "stimulus file missing");
        end
        else
        begin
            items = $fscanf(fd, "%s", name_buf);
            while (items == 1)
            begin
                if (first_char(name_buf) == "#")
                    items = $fgets(rest_buf, fd);
                else
                begin
                    items = $fscanf(fd, "%d %b %s %d %d %b %d %d %d %d",
                                    count_v, header_v, kind_buf, bypass_v, err_v,
                                    reads_v, hold_v, lock_v, sh_v, mm_v);
                    if (items != 10 || num_segs >= MAX_SEGS)
                    begin
                        $display("stimulus line for %0s could not be read", name_buf);
                        $display("Finished with errors");
                        $fatal(1, "bad stimulus file");
                    end
                    else
                    begin
                        seg_name[num_segs]   = name_buf;
                        seg_count[num_segs]  = count_v;
                        seg_header[num_segs] = header_v;
                        seg_random[num_segs] = (kind_buf == "random");
                        seg_bypass[num_segs] = (bypass_v != 0);
                        seg_errors[num_segs] = (err_v != 0);
                        seg_reads[num_segs]  = reads_v;
                        seg_hold[num_segs]   = (hold_v != 0);
                        exp_lock[num_segs]   = lock_v;
                        exp_sh[num_segs]     = sh_v;
                        exp_mm[num_segs]     = mm_v;
                        total += 2 * count_v + IDLE_CYCLES + READ_CYCLES;
                        num_segs++;
                    end
                end
                items = $fscanf(fd, "%s", name_buf);
            end
            $fclose(fd);
            cycle_limit = 2 * total + 100;
        end
    endtask

    initial
    begin
        reset           = 1'b1;
        valid           = 1'b0;
        block           = '0;
        bypass          = 1'b0;
        read_lock       = 1'b0;
        read_sh_errors  = 1'b0;
        read_mismatches = 1'b0;
        seed            = 32'hbb78;
        tx_state        = '0;
        load_stimulus();
        repeat (5) @(negedge clock);
        reset = 1'b0;
        for (int s = 0; s < num_segs; s++)
        begin
            bypass = seg_bypass[s];
            send_segment(s);
            // pipeline drains well inside this gap
            repeat (IDLE_CYCLES) @(negedge clock);
            check_outputs(seg_name[s], "segment end", exp_lock[s], exp_sh[s], exp_mm[s]);
            issue_reads(s);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

/* all.f */
hw/rx_pcs_pkg.sv
hw/block_lock.sv
hw/descrambler.sv
hw/idle_checker.sv
hw/status_bank.sv
hw/rx_pcs_top.sv
bench/rx_pcs_tb.sv

/* bench/rx_pcs_stimulus.txt */
# name count header kind bypass err_hdr reads hold exp_lock exp_sh_errors exp_mismatches
# reads bits are lock, sh_errors, mismatches; hold keeps them high through the next segment
# err_hdr puts header 00 or 11 on every fourth block of the segment
# expected values are sampled before the reads are issued

# lock acquisition, the 16th good header locks
acq_15          15 10 idle   0 0 000 0 0 0  0
acq_16           1 10 idle   0 0 000 0 1 0  0
idle_locked     20 10 idle   0 0 000 0 1 0  0

# pattern checking on data blocks and with the descrambler bypassed
random_data     10 01 random 0 0 001 0 1 0  10
bypass_idle      5 10 idle   1 0 001 0 1 0  5

# tolerated errors, 7 bad headers then the window closes and 3 more follow
tolerate        40 10 idle   0 1 011 0 1 10 10

# eighth bad header in the window drops lock
lose_lock       20 10 idle   0 1 000 0 0 5  4

# bad headers keep restarting the hunt count
hunt_errors     12 10 idle   0 1 000 0 0 8  4

# lock comes back but the flag stays low until read
regain          16 10 idle   0 0 111 0 0 8  4
relock_flag      4 10 idle   0 0 000 0 1 0  0

# held read clears once, later mismatches count again
hold_setup       4 01 random 0 0 001 1 1 0  4
hold_count       6 01 random 0 1 010 0 1 1  6
idle_final       8 10 idle   0 0 000 0 1 0  6
